// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - include
    files:
      - source/bus_pkg.sv
      - source/loader_pkg.sv
      - source/bus_ctrl.sv
      - source/byte_lane_ram.sv
      - source/cycle_timer.sv
      - source/prog_loader.sv
      - source/mem_subsystem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mem_subsystem_properties.sv
      - bench/mem_subsystem_tb.sv

// ==== bench/mem_subsystem_golden.txt ====
// Loader image: word count, then the words in RAM order from index 0
// Bus ops: op count, then per line kind addr wdata strobes expected (kind 0 write, 1 read)
00000006
1234abcd
cafef00d
0badc0de
89abcdef
5a5aa5a5
00c0ffee
// Bus operations
00000011
00000001 40000000 00000000 0 1234abcd
00000001 40000004 00000000 0 cafef00d
00000001 40000008 00000000 0 0badc0de
00000001 4000000c 00000000 0 89abcdef
00000001 40000010 00000000 0 5a5aa5a5
00000001 40000014 00000000 0 00c0ffee
00000000 40000040 deadbeef f 00000000
00000001 40000040 00000000 0 deadbeef
00000000 40000004 11223344 3 00000000
00000001 40000004 00000000 0 cafe3344
00000000 40000008 aabbccdd c 00000000
00000001 40000008 00000000 0 aabbc0de
00000000 4000000c 77665544 5 00000000
00000001 4000000c 00000000 0 8966cd44
00000001 20000000 00000000 0 00000000
00000000 20000000 ffffffff f 00000000
00000000 40100004 55555555 f 00000000

// ==== bench/mem_subsystem_properties.sv ====
`timescale 1ns/1ps
`include "mem_map_macros.svh"

module mem_subsystem_properties (
  input logic               clk_i,
  input logic               rst_n,
  input logic               valid_i,
  input bus_pkg::bus_word_t addr_i,
  input logic               ready_i,
  input logic               prog_mode_i,
  input logic               core_rst_n_i
);

  int unsigned assert_fail_cnt = 0;
  logic        ram_addr;

  assign ram_addr = (addr_i & ~`MEM_RAM_MASK) == `MEM_RAM_BASE;

  // Ready only answers a held request
  ready_with_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n) ready_i |-> valid_i
  ) else begin
    assert_fail_cnt++;
    $error("ready without valid");
  end

  ready_single: assert property (
    @(posedge clk_i) disable iff (!rst_n) ready_i |=> !ready_i
  ) else begin
    assert_fail_cnt++;
    $error("ready high for two cycles");
  end

  // Loader owns the RAM
  no_ram_ready_in_prog: assert property (
    @(posedge clk_i) disable iff (!rst_n) !(ready_i && prog_mode_i && ram_addr)
  ) else begin
    assert_fail_cnt++;
    $error("RAM ready during program mode");
  end

  core_rst_follows_prog: assert property (
    @(posedge clk_i) disable iff (!rst_n) core_rst_n_i == !prog_mode_i
  ) else begin
    assert_fail_cnt++;
    $error("core reset does not match program mode");
  end

endmodule

bind mem_subsystem_top mem_subsystem_properties u_props (
  .clk_i        (clk_i),
  .rst_n        (rst_n),
  .valid_i      (mem_valid_i),
  .addr_i       (mem_addr_i),
  .ready_i      (mem_ready_o),
  .prog_mode_i  (prog_mode_o),
  .core_rst_n_i (core_rst_no)
);

// ==== bench/mem_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "mem_map_macros.svh"

module mem_subsystem_tb;

  import bus_pkg::*;
  import loader_pkg::*;

  // Count, image words, op count, five words per op
  localparam int GOLD_LEN = 93;

  logic        clk_i;
  logic        rst_n;
  logic        mem_valid_i;
  bus_word_t   mem_addr_i;
  bus_word_t   mem_wdata_i;
  bus_strb_t   mem_wstrb_i;
  logic        mem_ready_o;
  bus_word_t   mem_rdata_o;
  logic        prog_rx_i;
  logic        core_rst_no;
  logic        prog_mode_o;

  logic [31:0] gold_mem [GOLD_LEN];
  bus_word_t   model_q  [`MEM_RAM_WORDS];
  logic        known_q  [`MEM_RAM_WORDS];
  int          img_len;
  int          op_cnt;
  int          limit_cycles;
  logic [31:0] lfsr_q;
  string       cur_test;
  int          test_errs;
  int          err_cnt;
  int          test_cnt;

  mem_subsystem_top UUT (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o),
    .prog_rx_i   (prog_rx_i),
    .core_rst_no (core_rst_no),
    .prog_mode_o (prog_mode_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, right shifting, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  function automatic mem_region_e region_of(input bus_word_t addr);
    if ((addr & ~`MEM_RAM_MASK) == `MEM_RAM_BASE) begin
      return REGION_RAM;
    end
    if (addr == `MEM_TIMER_LO || addr == `MEM_TIMER_HI) begin
      return REGION_TIMER;
    end
    return REGION_NONE;
  endfunction

  // Cycles from valid to ready by region
  function automatic int expected_latency(input bus_word_t addr);
    case (region_of(addr))
      REGION_RAM:   return `MEM_RAM_DELAY;
      REGION_TIMER: return 0;
      default:      return 1;
    endcase
  endfunction

  function automatic bus_word_t merge_lanes(input bus_word_t old_w, input bus_word_t new_w,
                                            input bus_strb_t strb);
    bus_word_t w;
    w = old_w;
    for (int l = 0; l < 4; l++) begin
      if (strb[l]) begin
        w[l*8 +: 8] = new_w[l*8 +: 8];
      end
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    test_cnt++;
    err_cnt += test_errs;
    if (test_errs == 0) begin
      $display("Test %s: ok", cur_test);
    end else begin
      $display("Test %s: %0d error(s)", cur_test, test_errs);
    end
  endtask

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error %s %s: expected 'h%0h, actual 'h%0h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic plain_error(input string msg);
    $display("Error in %s: %s", cur_test, msg);
    test_errs++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus master and serial line
  ////////////////////////////////////////////////////////////////////////////

  // Holds the request until ready, sampled on the falling edge
  task automatic bus_xfer(input bus_word_t addr, input bus_word_t wdata,
                          input bus_strb_t strb, output bus_word_t rdata,
                          output int lat, output logic rip);
    logic seen;
    seen = 1'b0;
    lat  = 0;
    rip  = 1'b0;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= strb;
    while (!seen) begin
      @(negedge clk_i);
      if (mem_ready_o === 1'b1) begin
        seen  = 1'b1;
        rdata = mem_rdata_o;
        rip   = prog_mode_o;
      end else begin
        lat++;
      end
    end
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= '0;
  endtask

  // 8N1, LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      prog_rx_i <= bits[i];
      repeat (`MEM_UART_BIT_CLKS - 1) @(posedge clk_i);
    end
  endtask

  task automatic send_frame();
    logic [31:0] w;
    send_byte(LOADER_MAGIC);
    send_byte(8'(img_len));
    send_byte(8'(img_len >> 8));
    for (int i = 0; i < img_len; i++) begin
      w = gold_mem[1 + i];
      for (int b = 0; b < 4; b++) begin
        send_byte(w[b*8 +: 8]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    bus_word_t rdata;
    bus_word_t t_first;
    bus_word_t addr;
    bus_word_t wdata;
    bus_word_t exp;
    bus_strb_t strb;
    int        lat;
    logic      rip;
    int        base;
    int        kind;
    int        gap;
    int        idle_n;
    int        waited;
    int        widx;
    logic      saw_prog;
    logic      rst_bad;
    logic      frame_done;

    clk_i       = 1'b0;
    rst_n       = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    prog_rx_i   = 1'b1;
    lfsr_q      = 32'h966c5d28;
    err_cnt     = 0;
    test_cnt    = 0;
    for (int i = 0; i < `MEM_RAM_WORDS; i++) begin
      known_q[i] = 1'b0;
    end

    $readmemh("bench/mem_subsystem_golden.txt", gold_mem);
    img_len = gold_mem[0];
    op_cnt  = gold_mem[img_len + 1];
    // Two frames plus every bus transfer with margin
    limit_cycles = 2 * (3 + 4 * img_len) * 10 * `MEM_UART_BIT_CLKS +
                   (op_cnt + `MEM_RAM_WORDS + 8) * (`MEM_RAM_DELAY + 32) + 64;

    repeat (4) @(posedge clk_i);
    rst_n <= 1'b1;

    begin_test("reset_state");
    @(negedge clk_i);
    if (prog_mode_o !== 1'b0) begin
      value_error("prog_mode_o", 0, prog_mode_o);
    end
    if (core_rst_no !== 1'b1) begin
      value_error("core_rst_no", 1, core_rst_no);
    end
    if (mem_ready_o !== 1'b0) begin
      value_error("mem_ready_o", 0, mem_ready_o);
    end
    end_test();

    begin_test("frame_load");
    saw_prog   = 1'b0;
    rst_bad    = 1'b0;
    frame_done = 1'b0;
    fork
      begin
        send_frame();
        frame_done = 1'b1;
      end
      begin
        while (!frame_done) begin
          @(negedge clk_i);
          if (prog_mode_o === 1'b1) begin
            saw_prog = 1'b1;
          end
          if (core_rst_no !== ~prog_mode_o) begin
            rst_bad = 1'b1;
          end
        end
      end
    join
    waited = 0;
    while (prog_mode_o !== 1'b0 && waited < 2 * `MEM_UART_BIT_CLKS) begin
      @(negedge clk_i);
      waited++;
    end
    if (!saw_prog) begin
      plain_error("prog_mode_o never rose during the frame");
    end
    if (rst_bad) begin
      plain_error("core_rst_no did not mirror prog_mode_o during the frame");
    end
    if (prog_mode_o !== 1'b0) begin
      plain_error("prog_mode_o stayed high after the last byte");
    end
    if (core_rst_no !== 1'b1) begin
      value_error("core_rst_no", 1, core_rst_no);
    end
    for (int i = 0; i < img_len; i++) begin
      model_q[i] = gold_mem[1 + i];
      known_q[i] = 1'b1;
    end
    end_test();

    begin_test("golden_ops");
    for (int k = 0; k < op_cnt; k++) begin
      base  = img_len + 2 + 5 * k;
      kind  = gold_mem[base];
      addr  = gold_mem[base + 1];
      wdata = gold_mem[base + 2];
      strb  = gold_mem[base + 3][3:0];
      exp   = gold_mem[base + 4];
      take_bits(2, gap);
      repeat (gap) @(posedge clk_i);
      bus_xfer(addr, wdata, strb, rdata, lat, rip);
      if (lat != expected_latency(addr)) begin
        value_error($sformatf("op %0d latency", k), expected_latency(addr), lat);
      end
      if (kind == 1 && rdata !== exp) begin
        value_error($sformatf("op %0d read at %h", k, addr), exp, rdata);
      end
      if (kind == 0 && region_of(addr) == REGION_RAM) begin
        widx = ((addr & `MEM_RAM_MASK) >> 2) % `MEM_RAM_WORDS;
        if (known_q[widx] || strb == 4'hf) begin
          model_q[widx] = merge_lanes(model_q[widx], wdata, strb);
          known_q[widx] = 1'b1;
        end
      end
    end
    end_test();

    begin_test("timer");
    bus_xfer(`MEM_TIMER_LO, '0, '0, t_first, lat, rip);
    take_bits(3, idle_n);
    idle_n += 8;
    repeat (idle_n) @(posedge clk_i);
    bus_xfer(`MEM_TIMER_LO, '0, '0, rdata, lat, rip);
    if (lat != 0) begin
      value_error("low half latency", 0, lat);
    end
    if (rdata - t_first < idle_n) begin
      value_error("low half step", idle_n, rdata - t_first);
    end
    bus_xfer(`MEM_TIMER_HI, '0, '0, rdata, lat, rip);
    if (rdata !== 32'h0) begin
      value_error("high half", 0, rdata);
    end
    end_test();

    // Unmapped writes above must not reach any RAM word
    begin_test("unmapped_readback");
    for (int i = 0; i < `MEM_RAM_WORDS; i++) begin
      if (known_q[i]) begin
        bus_xfer(`MEM_RAM_BASE + 32'(4 * i), '0, '0, rdata, lat, rip);
        if (rdata !== model_q[i]) begin
          value_error($sformatf("word %0d", i), model_q[i], rdata);
        end
      end
    end
    end_test();

    begin_test("prog_mode_stall");
    fork
      send_frame();
      begin
        while (prog_mode_o !== 1'b1) begin
          @(negedge clk_i);
        end
        bus_xfer(`MEM_RAM_BASE, '0, '0, rdata, lat, rip);
      end
    join
    if (rip) begin
      plain_error("ready arrived while prog_mode_o was high");
    end
    if (lat <= `MEM_RAM_DELAY) begin
      plain_error("RAM request was not held off during program mode");
    end
    if (rdata !== gold_mem[1]) begin
      value_error("word 0 after reload", gold_mem[1], rdata);
    end
    end_test();

    if (UUT.u_props.assert_fail_cnt != 0) begin
      $display("Error: %0d bus property assertion(s) failed", UUT.u_props.assert_fail_cnt);
      err_cnt++;
    end
    $display("Summary: %0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("Timeout: run still busy after %0d cycles", limit_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+include
source/bus_pkg.sv
source/loader_pkg.sv
source/bus_ctrl.sv
source/byte_lane_ram.sv
source/cycle_timer.sv
source/prog_loader.sv
source/mem_subsystem_top.sv
bench/mem_subsystem_properties.sv
bench/mem_subsystem_tb.sv

// ==== include/mem_map_macros.svh ====
`ifndef MEM_MAP_MACROS_SVH
`define MEM_MAP_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////////////////////

// RAM region base and the address bits ignored inside it
`define MEM_RAM_BASE 32'h4000_0000
`define MEM_RAM_MASK 32'h000f_ffff

// Cycle timer halves
`define MEM_TIMER_LO 32'h3000_0000
`define MEM_TIMER_HI 32'h3000_0004

////////////////////////////////////////////////////////////////////////////
// Sizes and timing
////////////////////////////////////////////////////////////////////////////

// RAM depth in 32-bit words
`define MEM_RAM_WORDS 256

// Cycles from first valid to ready for a RAM access
`define MEM_RAM_DELAY 16

// Clocks per bit on the program loader serial line
`define MEM_UART_BIT_CLKS 8

`endif

// ==== source/bus_ctrl.sv ====
`timescale 1ns/1ps
`include "mem_map_macros.svh"

module bus_ctrl (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                mem_valid_i,
  input  bus_pkg::bus_word_t  mem_addr_i,
  input  bus_pkg::bus_word_t  mem_wdata_i,
  input  bus_pkg::bus_strb_t  mem_wstrb_i,
  output logic                mem_ready_o,
  output bus_pkg::bus_word_t  mem_rdata_o,
  input  logic                prog_mode_i,
  input  logic                ld_we_i,
  input  bus_pkg::ram_idx_t   ld_word_idx_i,
  input  bus_pkg::bus_word_t  ld_wdata_i,
  output bus_pkg::bus_strb_t  ram_we_o,
  output bus_pkg::ram_idx_t   ram_idx_o,
  output bus_pkg::bus_word_t  ram_wdata_o,
  output logic                ram_re_o,
  input  bus_pkg::bus_word_t  ram_rdata_i,
  output logic                tmr_rd_lo_o,
  output logic                tmr_rd_hi_o,
  input  bus_pkg::bus_word_t  tmr_lo_i,
  input  bus_pkg::bus_word_t  tmr_hi_i
);

  import bus_pkg::*;

  localparam bus_word_t   RAM_BASE = `MEM_RAM_BASE;
  localparam bus_word_t   TMR_LO   = `MEM_TIMER_LO;
  localparam bus_word_t   TMR_HI   = `MEM_TIMER_HI;
  localparam int unsigned DLY_W    = $clog2(`MEM_RAM_DELAY + 1);

  bus_addr_u      addr_u;
  mem_region_e    region;
  logic           tmr_is_hi;
  logic           is_write;
  logic           tmr_acc;
  logic           ram_start;
  logic           ram_ready;
  logic           ram_busy_q;
  logic [DLY_W-1:0] dly_q;
  logic           unm_ready_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode through both views of the union
  ////////////////////////////////////////////////////////////////////////////

  assign addr_u    = mem_addr_i;
  assign is_write  = |mem_wstrb_i;
  assign tmr_is_hi = addr_u.io.reg_sel == TMR_HI[3:2];

  always_comb begin
    region = REGION_NONE;
    if (addr_u.ram.region == RAM_BASE[31 -: RAM_REGION_W]) begin
      region = REGION_RAM;
    end else if (addr_u.io.io_base == TMR_LO[31 -: IO_BASE_W] &&
                 addr_u.io.byte_off == 2'b00 &&
                 (addr_u.io.reg_sel == TMR_LO[3:2] || tmr_is_hi)) begin
      region = REGION_TIMER;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // RAM request timing
  ////////////////////////////////////////////////////////////////////////////

  // Held off while the loader owns the RAM
  assign ram_start = mem_valid_i & (region == REGION_RAM) & ~ram_busy_q &
                     ~prog_mode_i & ~ld_we_i;
  assign ram_ready = ram_busy_q & (dly_q == DLY_W'(`MEM_RAM_DELAY));

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ram_busy_q <= 1'b0;
      dly_q      <= '0;
    end else if (ram_start) begin
      ram_busy_q <= 1'b1;
      dly_q      <= DLY_W'(1);
    end else if (ram_ready) begin
      ram_busy_q <= 1'b0;
      dly_q      <= '0;
    end else if (ram_busy_q) begin
      dly_q <= dly_q + DLY_W'(1);
    end
  end

  // Unmapped access answers one cycle late
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      unm_ready_q <= 1'b0;
    end else begin
      unm_ready_q <= mem_valid_i & (region == REGION_NONE) & ~unm_ready_q;
    end
  end

  assign tmr_acc     = mem_valid_i & (region == REGION_TIMER);
  assign tmr_rd_lo_o = tmr_acc & ~is_write & ~tmr_is_hi;
  assign tmr_rd_hi_o = tmr_acc & ~is_write & tmr_is_hi;

  assign mem_ready_o = ram_ready | tmr_acc | unm_ready_q;

  ////////////////////////////////////////////////////////////////////////////
  // RAM port, loader first
  ////////////////////////////////////////////////////////////////////////////

  assign ram_we_o    = ld_we_i ? 4'hf : (ram_start ? mem_wstrb_i : 4'h0);
  assign ram_idx_o   = ld_we_i ? ld_word_idx_i : addr_u.ram.word_idx[$bits(ram_idx_t)-1:0];
  assign ram_wdata_o = ld_we_i ? ld_wdata_i : mem_wdata_i;
  assign ram_re_o    = ram_start & ~is_write;

  // Read data by region, unmapped reads as zero
  always_comb begin
    case (region)
      REGION_RAM:   mem_rdata_o = ram_rdata_i;
      REGION_TIMER: mem_rdata_o = tmr_is_hi ? tmr_hi_i : tmr_lo_i;
      default:      mem_rdata_o = '0;
    endcase
  end

endmodule

// ==== source/bus_pkg.sv ====
`include "mem_map_macros.svh"

package bus_pkg;

  typedef logic [31:0] bus_word_t;
  typedef logic [3:0]  bus_strb_t;

  // Word index into the RAM array
  typedef logic [$clog2(`MEM_RAM_WORDS)-1:0] ram_idx_t;

  // Split of the RAM view, region bits above the masked window
  localparam int unsigned RAM_OFF_W    = $clog2(`MEM_RAM_MASK + 1);
  localparam int unsigned RAM_REGION_W = 32 - RAM_OFF_W;
  localparam int unsigned RAM_WIDX_W   = RAM_OFF_W - 2;

  // Split of the IO view, four registers per block
  localparam int unsigned IO_SEL_W  = 2;
  localparam int unsigned IO_BASE_W = 32 - IO_SEL_W - 2;

  typedef struct packed {
    logic [RAM_REGION_W-1:0] region;
    logic [RAM_WIDX_W-1:0]   word_idx;
    logic [1:0]              byte_off;
  } ram_view_t;

  typedef struct packed {
    logic [IO_BASE_W-1:0] io_base;
    logic [IO_SEL_W-1:0]  reg_sel;
    logic [1:0]           byte_off;
  } io_view_t;

  // One bus address, read either as RAM or as IO register
  typedef union packed {
    ram_view_t ram;
    io_view_t  io;
  } bus_addr_u;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_TIMER,
    REGION_NONE
  } mem_region_e;

endpackage

// ==== source/byte_lane_ram.sv ====
`timescale 1ns/1ps
`include "mem_map_macros.svh"

module byte_lane_ram (
  input  logic                clk_i,
  input  bus_pkg::bus_strb_t  we_i,
  input  bus_pkg::ram_idx_t   idx_i,
  input  bus_pkg::bus_word_t  wdata_i,
  input  logic                re_i,
  output bus_pkg::bus_word_t  rdata_o
);

  import bus_pkg::*;

  localparam int unsigned LANES = $bits(bus_strb_t);

  bus_word_t mem_q [`MEM_RAM_WORDS];
  bus_word_t rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // Byte-lane write
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int lane = 0; lane < LANES; lane++) begin
      if (we_i[lane]) begin
        mem_q[idx_i][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered read
  ////////////////////////////////////////////////////////////////////////////

  // Keeps its word until the next read enable
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_q <= mem_q[idx_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== source/cycle_timer.sv ====
`timescale 1ns/1ps

module cycle_timer (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                rd_lo_i,
  input  logic                rd_hi_i,
  output bus_pkg::bus_word_t  lo_o,
  output bus_pkg::bus_word_t  hi_o
);

  logic [63:0] cnt_q;
  logic [31:0] hi_cap_q;
  logic        cap_valid_q;

  // Free running, cleared with the core
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 64'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_lo_i) begin
      hi_cap_q <= cnt_q[63:32];
    end
  end

  // Capture stays in use until the high half is read
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      cap_valid_q <= 1'b0;
    end else if (rd_lo_i) begin
      cap_valid_q <= 1'b1;
    end else if (rd_hi_i) begin
      cap_valid_q <= 1'b0;
    end
  end

  assign lo_o = cnt_q[31:0];
  assign hi_o = cap_valid_q ? hi_cap_q : cnt_q[63:32];

endmodule

// ==== source/loader_pkg.sv ====
package loader_pkg;

  // Frame parser states
  typedef enum logic [1:0] {
    LD_IDLE,
    LD_CNT_LO,
    LD_CNT_HI,
    LD_DATA
  } loader_state_e;

  typedef logic [7:0] loader_byte_t;

  // First byte of every frame
  localparam loader_byte_t LOADER_MAGIC = 8'hA5;

  // Word count field, sent low byte first
  localparam int unsigned LOADER_COUNT_W = 16;
  typedef logic [LOADER_COUNT_W-1:0] loader_count_t;

  // Bytes per payload word, LSB first on the line
  localparam int unsigned LOADER_WORD_BYTES = 4;
  localparam int unsigned LOADER_SEL_W      = $clog2(LOADER_WORD_BYTES);

endpackage

// ==== source/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                mem_valid_i,
  input  bus_pkg::bus_word_t  mem_addr_i,
  input  bus_pkg::bus_word_t  mem_wdata_i,
  input  bus_pkg::bus_strb_t  mem_wstrb_i,
  output logic                mem_ready_o,
  output bus_pkg::bus_word_t  mem_rdata_o,
  input  logic                prog_rx_i,
  output logic                core_rst_no,
  output logic                prog_mode_o
);

  import bus_pkg::*;

  logic      ld_we;
  ram_idx_t  ld_word_idx;
  bus_word_t ld_wdata;
  bus_strb_t ram_we;
  ram_idx_t  ram_idx;
  bus_word_t ram_wdata;
  logic      ram_re;
  bus_word_t ram_rdata;
  logic      tmr_rd_lo;
  logic      tmr_rd_hi;
  bus_word_t tmr_lo;
  bus_word_t tmr_hi;

  bus_ctrl u_bus_ctrl (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .mem_valid_i   (mem_valid_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wdata_i   (mem_wdata_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .mem_ready_o   (mem_ready_o),
    .mem_rdata_o   (mem_rdata_o),
    .prog_mode_i   (prog_mode_o),
    .ld_we_i       (ld_we),
    .ld_word_idx_i (ld_word_idx),
    .ld_wdata_i    (ld_wdata),
    .ram_we_o      (ram_we),
    .ram_idx_o     (ram_idx),
    .ram_wdata_o   (ram_wdata),
    .ram_re_o      (ram_re),
    .ram_rdata_i   (ram_rdata),
    .tmr_rd_lo_o   (tmr_rd_lo),
    .tmr_rd_hi_o   (tmr_rd_hi),
    .tmr_lo_i      (tmr_lo),
    .tmr_hi_i      (tmr_hi)
  );

  byte_lane_ram u_ram (
    .clk_i   (clk_i),
    .we_i    (ram_we),
    .idx_i   (ram_idx),
    .wdata_i (ram_wdata),
    .re_i    (ram_re),
    .rdata_o (ram_rdata)
  );

  // Timer restarts along with the core
  cycle_timer u_timer (
    .clk_i   (clk_i),
    .rst_n   (rst_n & core_rst_no),
    .rd_lo_i (tmr_rd_lo),
    .rd_hi_i (tmr_rd_hi),
    .lo_o    (tmr_lo),
    .hi_o    (tmr_hi)
  );

  prog_loader u_loader (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .rx_i        (prog_rx_i),
    .prog_mode_o (prog_mode_o),
    .core_rst_no (core_rst_no),
    .we_o        (ld_we),
    .word_idx_o  (ld_word_idx),
    .wdata_o     (ld_wdata)
  );

endmodule

// ==== source/prog_loader.sv ====
`timescale 1ns/1ps
`include "mem_map_macros.svh"

module prog_loader (
  input  logic                clk_i,
  input  logic                rst_n,
  input  logic                rx_i,
  output logic                prog_mode_o,
  output logic                core_rst_no,
  output logic                we_o,
  output bus_pkg::ram_idx_t   word_idx_o,
  output bus_pkg::bus_word_t  wdata_o
);

  import loader_pkg::*;

  localparam int unsigned CLK_W = $clog2(`MEM_UART_BIT_CLKS);
  localparam int unsigned HALF  = `MEM_UART_BIT_CLKS / 2;

  logic [1:0]              rx_sync_q;
  logic                    rx_s;
  logic                    rx_busy_q;
  logic [CLK_W-1:0]        clk_cnt_q;
  logic [3:0]              bit_idx_q;
  loader_byte_t            shift_q;
  logic                    byte_rdy_q;
  loader_state_e           state_q;
  loader_count_t           left_q;
  logic [LOADER_SEL_W-1:0] byte_sel_q;
  logic [23:0]             word_q;
  logic [$bits(word_idx_o)-1:0] idx_q;
  logic                    prog_q;

  ////////////////////////////////////////////////////////////////////////////
  // 8N1 receiver, sampled mid-bit
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
    end
  end

  assign rx_s = rx_sync_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_busy_q  <= 1'b0;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      byte_rdy_q <= 1'b0;
    end else begin
      byte_rdy_q <= 1'b0;
      if (!rx_busy_q) begin
        // Falling edge opens a start bit
        if (!rx_s) begin
          rx_busy_q <= 1'b1;
          clk_cnt_q <= CLK_W'(HALF - 1);
          bit_idx_q <= '0;
        end
      end else if (clk_cnt_q != '0) begin
        clk_cnt_q <= clk_cnt_q - CLK_W'(1);
      end else begin
        clk_cnt_q <= CLK_W'(`MEM_UART_BIT_CLKS - 1);
        bit_idx_q <= bit_idx_q + 4'd1;
        if (bit_idx_q == 4'd0 && rx_s) begin
          rx_busy_q <= 1'b0;  // glitch, not a start bit
        end else if (bit_idx_q == 4'd9) begin
          rx_busy_q  <= 1'b0;
          byte_rdy_q <= rx_s;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (rx_busy_q && clk_cnt_q == '0 && bit_idx_q != 4'd0 && bit_idx_q != 4'd9) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame parser
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q    <= LD_IDLE;
      prog_q     <= 1'b0;
      left_q     <= '0;
      byte_sel_q <= '0;
      idx_q      <= '0;
    end else if (byte_rdy_q) begin
      case (state_q)
        LD_IDLE: begin
          if (shift_q == LOADER_MAGIC) begin
            state_q <= LD_CNT_LO;
            prog_q  <= 1'b1;
          end
        end
        LD_CNT_LO: begin
          left_q[7:0] <= shift_q;
          state_q     <= LD_CNT_HI;
        end
        LD_CNT_HI: begin
          left_q[15:8] <= shift_q;
          byte_sel_q   <= '0;
          idx_q        <= '0;
          // Empty frame ends here
          if ({shift_q, left_q[7:0]} == '0) begin
            state_q <= LD_IDLE;
            prog_q  <= 1'b0;
          end else begin
            state_q <= LD_DATA;
          end
        end
        default: begin
          byte_sel_q <= byte_sel_q + 1'b1;
          if (byte_sel_q == LOADER_SEL_W'(LOADER_WORD_BYTES - 1)) begin
            left_q <= left_q - 1'b1;
            idx_q  <= idx_q + 1'b1;
            if (left_q == loader_count_t'(1)) begin
              state_q <= LD_IDLE;
              prog_q  <= 1'b0;
            end
          end
        end
      endcase
    end
  end

  // Lower three bytes of the word in flight
  always_ff @(posedge clk_i) begin
    if (byte_rdy_q && state_q == LD_DATA &&
        byte_sel_q != LOADER_SEL_W'(LOADER_WORD_BYTES - 1)) begin
      word_q[{byte_sel_q, 3'b000} +: 8] <= shift_q;
    end
  end

  assign we_o = byte_rdy_q & (state_q == LD_DATA) &
                (byte_sel_q == LOADER_SEL_W'(LOADER_WORD_BYTES - 1));
  assign wdata_o     = {shift_q, word_q};
  assign word_idx_o  = idx_q;
  assign prog_mode_o = prog_q;
  assign core_rst_no = ~prog_q;

endmodule
